/* verilog/gpr_pkg.sv */
package gpr_pkg;

    // Register file geometry
    localparam int NUM_REGS = 8;
    localparam int IDX_W    = 3;
    localparam int DATA_W   = 32;
    localparam int TAG_W    = 7;
    localparam int NUM_SECT = 3;

    // Section positions inside a section-enable vector
    localparam int SECT_E = 2;
    localparam int SECT_H = 1;
    localparam int SECT_L = 0;

    // Access size where code 2'b11 is illegal
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } size_t;

    // Producer tag id
    typedef logic [TAG_W-1:0] tag_t;

    // One enable bit per section in E H L order
    typedef logic [NUM_SECT-1:0] sect_en_t;

endpackage

/* verilog/size_decode.sv */
`timescale 1ns/1ps

module size_decode (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          wr_en,
    input  logic [gpr_pkg::IDX_W-1:0]                     wr_idx,
    input  gpr_pkg::size_t                                wr_size,
    input  logic [gpr_pkg::DATA_W-1:0]                    wr_data,
    input  logic                                          alloc_en,
    input  logic [gpr_pkg::IDX_W-1:0]                     alloc_idx,
    input  gpr_pkg::size_t                                alloc_size,
    input  gpr_pkg::tag_t                                 alloc_tag,
    input  logic                                          cdb_en,
    input  gpr_pkg::tag_t                                 cdb_tag,
    input  logic                                          flush,
    input  logic                                          rd_en,
    input  logic [gpr_pkg::IDX_W-1:0]                     rd_idx,
    input  gpr_pkg::size_t                                rd_size,
    output gpr_pkg::sect_en_t [gpr_pkg::NUM_REGS-1:0]     wr_sect,
    output logic [gpr_pkg::DATA_W-1:0]                    wr_word,
    output gpr_pkg::sect_en_t [gpr_pkg::NUM_REGS-1:0]     alloc_sect,
    output gpr_pkg::tag_t                                 alloc_tag_q,
    output logic                                          cdb_en_q,
    output gpr_pkg::tag_t                                 cdb_tag_q,
    output logic                                          flush_q,
    output logic                                          rd_en_q,
    output logic [gpr_pkg::IDX_W-1:0]                     rd_slot,
    output gpr_pkg::sect_en_t                             rd_sect,
    output logic                                          rd_high_byte
);

    import gpr_pkg::*;

    // Byte index 4-7 folds onto register index-4
    function automatic logic [IDX_W-1:0] slot_of(input logic [IDX_W-1:0] idx, input size_t size);
        slot_of = (size == SIZE_BYTE) ? {1'b0, idx[IDX_W-2:0]} : idx;
    endfunction

    function automatic sect_en_t sect_of(input logic [IDX_W-1:0] idx, input size_t size);
        sect_en_t s;
        s = '0;
        case (size)
            SIZE_BYTE: begin
                if (idx[IDX_W-1]) begin
                    s[SECT_H] = 1'b1;
                end else begin
                    s[SECT_L] = 1'b1;
                end
            end
            SIZE_WORD: begin
                s[SECT_H] = 1'b1;
                s[SECT_L] = 1'b1;
            end
            SIZE_DWORD: s = '1;
            default:    s = '0;
        endcase
        return s;
    endfunction

    logic [IDX_W-1:0] wr_slot_d;
    logic [IDX_W-1:0] alloc_slot_d;
    sect_en_t         wr_sect_d;
    sect_en_t         alloc_sect_d;
    logic             wr_high;

    always_comb begin
        wr_slot_d    = slot_of(wr_idx, wr_size);
        wr_sect_d    = sect_of(wr_idx, wr_size);
        alloc_slot_d = slot_of(alloc_idx, alloc_size);
        alloc_sect_d = sect_of(alloc_idx, alloc_size);
        wr_high      = (wr_size == SIZE_BYTE) && wr_idx[IDX_W-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_sect    <= '0;
            alloc_sect <= '0;
            cdb_en_q   <= 1'b0;
            flush_q    <= 1'b0;
            rd_en_q    <= 1'b0;
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                wr_sect[r]    <= (wr_en && wr_slot_d == IDX_W'(r)) ? wr_sect_d : '0;
                alloc_sect[r] <= (alloc_en && alloc_slot_d == IDX_W'(r)) ? alloc_sect_d : '0;
            end
            cdb_en_q <= cdb_en;
            flush_q  <= flush;
            rd_en_q  <= rd_en;
        end
    end

    // High byte data moves into the H lane
    always_ff @(posedge clk) begin
        wr_word      <= wr_high ? {wr_data[31:16], wr_data[7:0], wr_data[7:0]} : wr_data;
        alloc_tag_q  <= alloc_tag;
        cdb_tag_q    <= cdb_tag;
        rd_slot      <= slot_of(rd_idx, rd_size);
        rd_sect      <= sect_of(rd_idx, rd_size);
        rd_high_byte <= (rd_size == SIZE_BYTE) && rd_idx[IDX_W-1];
    end

    a_wr_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_size inside {SIZE_BYTE, SIZE_WORD, SIZE_DWORD})
        else $error("illegal write size");

    a_alloc_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_en |-> alloc_size inside {SIZE_BYTE, SIZE_WORD, SIZE_DWORD})
        else $error("illegal allocate size");

    a_rd_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> rd_size inside {SIZE_BYTE, SIZE_WORD, SIZE_DWORD})
        else $error("illegal read size");

endmodule

/* verilog/gpr_slot.sv */
`timescale 1ns/1ps

module gpr_slot (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  gpr_pkg::sect_en_t                            wr_sect,
    input  logic [gpr_pkg::DATA_W-1:0]                   wr_word,
    input  gpr_pkg::sect_en_t                            alloc_sect,
    input  gpr_pkg::tag_t                                alloc_tag,
    input  logic                                         cdb_en,
    input  gpr_pkg::tag_t                                cdb_tag,
    input  logic                                         flush,
    output logic [gpr_pkg::DATA_W-1:0]                   data,
    output gpr_pkg::sect_en_t                            tag_v,
    output gpr_pkg::tag_t [gpr_pkg::NUM_SECT-1:0]        tags
);

    import gpr_pkg::*;

    // E, H and L data sections
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data <= '0;
        end else begin
            if (wr_sect[SECT_E]) begin
                data[31:16] <= wr_word[31:16];
            end
            if (wr_sect[SECT_H]) begin
                data[15:8] <= wr_word[15:8];
            end
            if (wr_sect[SECT_L]) begin
                data[7:0] <= wr_word[7:0];
            end
        end
    end

    // Flush first, then allocate, then a matching broadcast
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_v <= '0;
        end else begin
            for (int s = 0; s < NUM_SECT; s++) begin
                if (flush) begin
                    tag_v[s] <= 1'b0;
                end else if (alloc_sect[s]) begin
                    tag_v[s] <= 1'b1;
                end else if (cdb_en && tags[s] == cdb_tag) begin
                    tag_v[s] <= 1'b0;
                end
            end
        end
    end

    // Tag ids load on allocation
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SECT; s++) begin
            if (alloc_sect[s]) begin
                tags[s] <= alloc_tag;
            end
        end
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> tag_v == '0)
        else $error("valid bit survived a flush");

endmodule

/* verilog/gpr_array.sv */
`timescale 1ns/1ps

module gpr_array (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  gpr_pkg::sect_en_t [gpr_pkg::NUM_REGS-1:0]    wr_sect,
    input  logic [gpr_pkg::DATA_W-1:0]                   wr_word,
    input  gpr_pkg::sect_en_t [gpr_pkg::NUM_REGS-1:0]    alloc_sect,
    input  gpr_pkg::tag_t                                alloc_tag_q,
    input  logic                                         cdb_en_q,
    input  gpr_pkg::tag_t                                cdb_tag_q,
    input  logic                                         flush_q,
    input  logic                                         rd_en_q,
    input  logic [gpr_pkg::IDX_W-1:0]                    rd_slot,
    input  gpr_pkg::sect_en_t                            rd_sect,
    input  logic                                         rd_high_byte,
    output logic                                         cap_valid,
    output logic [gpr_pkg::DATA_W-1:0]                   cap_data,
    output gpr_pkg::sect_en_t                            cap_sect,
    output logic                                         cap_high_byte,
    output gpr_pkg::sect_en_t                            cap_tag_v,
    output gpr_pkg::tag_t [gpr_pkg::NUM_SECT-1:0]        cap_tags
);

    import gpr_pkg::*;

    logic [DATA_W-1:0]         slot_data  [NUM_REGS];
    sect_en_t                  slot_tag_v [NUM_REGS];
    tag_t [NUM_SECT-1:0]       slot_tags  [NUM_REGS];

    for (genvar g = 0; g < NUM_REGS; g++) begin : g_slot
        gpr_slot u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr_sect    (wr_sect[g]),
            .wr_word    (wr_word),
            .alloc_sect (alloc_sect[g]),
            .alloc_tag  (alloc_tag_q),
            .cdb_en     (cdb_en_q),
            .cdb_tag    (cdb_tag_q),
            .flush      (flush_q),
            .data       (slot_data[g]),
            .tag_v      (slot_tag_v[g]),
            .tags       (slot_tags[g])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= rd_en_q;
        end
    end

    // Slot outputs still hold the state from before this edge
    always_ff @(posedge clk) begin
        cap_data      <= slot_data[rd_slot];
        cap_tag_v     <= slot_tag_v[rd_slot];
        cap_tags      <= slot_tags[rd_slot];
        cap_sect      <= rd_sect;
        cap_high_byte <= rd_high_byte;
    end

endmodule

/* verilog/read_format.sv */
`timescale 1ns/1ps

module read_format (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         cap_valid,
    input  logic [gpr_pkg::DATA_W-1:0]                   cap_data,
    input  gpr_pkg::sect_en_t                            cap_sect,
    input  logic                                         cap_high_byte,
    input  gpr_pkg::sect_en_t                            cap_tag_v,
    input  gpr_pkg::tag_t [gpr_pkg::NUM_SECT-1:0]        cap_tags,
    output logic                                         rd_valid,
    output logic [gpr_pkg::DATA_W-1:0]                   rd_data,
    output logic                                         rd_busy,
    output gpr_pkg::tag_t                                rd_tag
);

    import gpr_pkg::*;

    logic [DATA_W-1:0] field;
    sect_en_t          pend;
    tag_t              tag_d;

    // Size follows from the touched sections
    always_comb begin
        if (cap_sect[SECT_E]) begin
            field = cap_data;
        end else if (cap_sect[SECT_H] && cap_sect[SECT_L]) begin
            field = {{16{cap_data[15]}}, cap_data[15:0]};
        end else if (cap_high_byte) begin
            field = {{24{cap_data[15]}}, cap_data[15:8]};
        end else begin
            field = {{24{cap_data[7]}}, cap_data[7:0]};
        end
    end

    // Most significant pending section wins
    always_comb begin
        pend = cap_tag_v & cap_sect;
        if (pend[SECT_E]) begin
            tag_d = cap_tags[SECT_E];
        end else if (pend[SECT_H]) begin
            tag_d = cap_tags[SECT_H];
        end else if (pend[SECT_L]) begin
            tag_d = cap_tags[SECT_L];
        end else begin
            tag_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= field;
        rd_busy <= |pend;
        rd_tag  <= tag_d;
    end

endmodule

/* verilog/gpr_regfile.sv */
`timescale 1ns/1ps

module gpr_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic [gpr_pkg::IDX_W-1:0]     wr_idx,
    input  gpr_pkg::size_t                wr_size,
    input  logic [gpr_pkg::DATA_W-1:0]    wr_data,
    input  logic                          alloc_en,
    input  logic [gpr_pkg::IDX_W-1:0]     alloc_idx,
    input  gpr_pkg::size_t                alloc_size,
    input  gpr_pkg::tag_t                 alloc_tag,
    input  logic                          cdb_en,
    input  gpr_pkg::tag_t                 cdb_tag,
    input  logic                          flush,
    input  logic                          rd_en,
    input  logic [gpr_pkg::IDX_W-1:0]     rd_idx,
    input  gpr_pkg::size_t                rd_size,
    output logic                          rd_valid,
    output logic [gpr_pkg::DATA_W-1:0]    rd_data,
    output logic                          rd_busy,
    output gpr_pkg::tag_t                 rd_tag
);

    import gpr_pkg::*;

    // Decode to array
    sect_en_t [NUM_REGS-1:0] wr_sect;
    logic [DATA_W-1:0]       wr_word;
    sect_en_t [NUM_REGS-1:0] alloc_sect;
    tag_t                    alloc_tag_q;
    logic                    cdb_en_q;
    tag_t                    cdb_tag_q;
    logic                    flush_q;
    logic                    rd_en_q;
    logic [IDX_W-1:0]        rd_slot;
    sect_en_t                rd_sect;
    logic                    rd_high_byte;

    // Array to format
    logic                    cap_valid;
    logic [DATA_W-1:0]       cap_data;
    sect_en_t                cap_sect;
    logic                    cap_high_byte;
    sect_en_t                cap_tag_v;
    tag_t [NUM_SECT-1:0]     cap_tags;

    size_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_size      (wr_size),
        .wr_data      (wr_data),
        .alloc_en     (alloc_en),
        .alloc_idx    (alloc_idx),
        .alloc_size   (alloc_size),
        .alloc_tag    (alloc_tag),
        .cdb_en       (cdb_en),
        .cdb_tag      (cdb_tag),
        .flush        (flush),
        .rd_en        (rd_en),
        .rd_idx       (rd_idx),
        .rd_size      (rd_size),
        .wr_sect      (wr_sect),
        .wr_word      (wr_word),
        .alloc_sect   (alloc_sect),
        .alloc_tag_q  (alloc_tag_q),
        .cdb_en_q     (cdb_en_q),
        .cdb_tag_q    (cdb_tag_q),
        .flush_q      (flush_q),
        .rd_en_q      (rd_en_q),
        .rd_slot      (rd_slot),
        .rd_sect      (rd_sect),
        .rd_high_byte (rd_high_byte)
    );

    gpr_array u_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_sect       (wr_sect),
        .wr_word       (wr_word),
        .alloc_sect    (alloc_sect),
        .alloc_tag_q   (alloc_tag_q),
        .cdb_en_q      (cdb_en_q),
        .cdb_tag_q     (cdb_tag_q),
        .flush_q       (flush_q),
        .rd_en_q       (rd_en_q),
        .rd_slot       (rd_slot),
        .rd_sect       (rd_sect),
        .rd_high_byte  (rd_high_byte),
        .cap_valid     (cap_valid),
        .cap_data      (cap_data),
        .cap_sect      (cap_sect),
        .cap_high_byte (cap_high_byte),
        .cap_tag_v     (cap_tag_v),
        .cap_tags      (cap_tags)
    );

    read_format u_format (
        .clk           (clk),
        .rst_n         (rst_n),
        .cap_valid     (cap_valid),
        .cap_data      (cap_data),
        .cap_sect      (cap_sect),
        .cap_high_byte (cap_high_byte),
        .cap_tag_v     (cap_tag_v),
        .cap_tags      (cap_tags),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_busy       (rd_busy),
        .rd_tag        (rd_tag)
    );

endmodule

/* tb/gpr_model.svh */
`ifndef GPR_MODEL_SVH
`define GPR_MODEL_SVH

// Expected read result and the edge count at which rd_valid must be seen
typedef struct packed {
    logic [31:0] data;
    logic        busy;
    tag_t        tag;
    logic [31:0] due;
} exp_rd_t;

logic [DATA_W-1:0] m_data  [NUM_REGS];
sect_en_t          m_valid [NUM_REGS];
tag_t              m_tags  [NUM_REGS][NUM_SECT];
exp_rd_t           exp_q [$];

// Byte index 4-7 names the H section of register index-4
function automatic int reg_of(input int idx, input size_t size);
    if (size == SIZE_BYTE && idx >= 4) begin
        return idx - 4;
    end
    return idx;
endfunction

// Bits ordered E H L
function automatic sect_en_t sections_of(input int idx, input size_t size);
    case (size)
        SIZE_BYTE: return (idx >= 4) ? 3'b010 : 3'b001;
        SIZE_WORD: return 3'b011;
        default:   return 3'b111;
    endcase
endfunction

task automatic model_reset();
    for (int r = 0; r < NUM_REGS; r++) begin
        m_data[r]  = '0;
        m_valid[r] = '0;
        for (int s = 0; s < NUM_SECT; s++) begin
            m_tags[r][s] = '0;
        end
    end
    exp_q.delete();
endtask

function automatic exp_rd_t predict_read(input int idx, input size_t size, input int due);
    exp_rd_t  e;
    int       r;
    sect_en_t pend;
    r = reg_of(idx, size);
    case (size)
        SIZE_BYTE: begin
            if (idx >= 4) begin
                e.data = {{24{m_data[r][15]}}, m_data[r][15:8]};
            end else begin
                e.data = {{24{m_data[r][7]}}, m_data[r][7:0]};
            end
        end
        SIZE_WORD: e.data = {{16{m_data[r][15]}}, m_data[r][15:0]};
        default:   e.data = m_data[r];
    endcase
    pend   = m_valid[r] & sections_of(idx, size);
    e.busy = |pend;
    if (pend[2]) begin
        e.tag = m_tags[r][2];
    end else if (pend[1]) begin
        e.tag = m_tags[r][1];
    end else if (pend[0]) begin
        e.tag = m_tags[r][0];
    end else begin
        e.tag = '0;
    end
    e.due = due;
    return e;
endfunction

task automatic model_update(input logic w_en, input int w_idx, input size_t w_size,
                            input logic [31:0] w_data, input logic a_en, input int a_idx,
                            input size_t a_size, input tag_t a_tag, input logic c_en,
                            input tag_t c_tag, input logic fl);
    int       wr;
    int       ar;
    sect_en_t wm;
    sect_en_t am;
    logic     hit;
    wr = reg_of(w_idx, w_size);
    wm = w_en ? sections_of(w_idx, w_size) : 3'b000;
    ar = reg_of(a_idx, a_size);
    am = a_en ? sections_of(a_idx, a_size) : 3'b000;
    for (int r = 0; r < NUM_REGS; r++) begin
        for (int s = 0; s < NUM_SECT; s++) begin
            hit = (r == ar) && am[s];
            if (fl) begin
                m_valid[r][s] = 1'b0;
            end else if (hit) begin
                m_valid[r][s] = 1'b1;
            end else if (c_en && m_tags[r][s] == c_tag) begin
                m_valid[r][s] = 1'b0;
            end
            if (hit) begin
                m_tags[r][s] = a_tag;
            end
        end
    end
    if (wm[2]) begin
        m_data[wr][31:16] = w_data[31:16];
    end
    // A high byte write takes its value from the low lane of the data
    if (wm[1]) begin
        m_data[wr][15:8] = (w_size == SIZE_BYTE) ? w_data[7:0] : w_data[15:8];
    end
    if (wm[0]) begin
        m_data[wr][7:0] = w_data[7:0];
    end
endtask

`endif

/* tb/gpr_regfile_tb.sv */
`timescale 1ns/1ps

module gpr_regfile_tb;

    import gpr_pkg::*;

    `include "gpr_model.svh"

    localparam int RESET_CYCLES = 5;
    localparam int STIM_CYCLES  = 2000;
    // Reset, stimulus and pipeline drain with margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + 95;

    logic              clk;
    logic              rst_n;
    logic              wr_en;
    logic [IDX_W-1:0]  wr_idx;
    size_t             wr_size;
    logic [DATA_W-1:0] wr_data;
    logic              alloc_en;
    logic [IDX_W-1:0]  alloc_idx;
    size_t             alloc_size;
    tag_t              alloc_tag;
    logic              cdb_en;
    tag_t              cdb_tag;
    logic              flush;
    logic              rd_en;
    logic [IDX_W-1:0]  rd_idx;
    size_t             rd_size;
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;
    logic              rd_busy;
    tag_t              rd_tag;

    logic [31:0] rng = 32'd7;
    int          edge_cnt = 0;
    int          checked = 0;
    int          drain;
    tag_t        recent_tags [8];
    int          pool_ptr = 0;
    exp_rd_t     head;

    gpr_regfile DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_size    (wr_size),
        .wr_data    (wr_data),
        .alloc_en   (alloc_en),
        .alloc_idx  (alloc_idx),
        .alloc_size (alloc_size),
        .alloc_tag  (alloc_tag),
        .cdb_en     (cdb_en),
        .cdb_tag    (cdb_tag),
        .flush      (flush),
        .rd_en      (rd_en),
        .rd_idx     (rd_idx),
        .rd_size    (rd_size),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_busy    (rd_busy),
        .rd_tag     (rd_tag)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic value_mismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] want);
        report_failure($sformatf("Fail at %0t ns: %s is 0x%08h, expected 0x%08h",
                                 $time, field, got, want));
    endtask

    task automatic drive_idle();
        wr_en      = 1'b0;
        wr_idx     = '0;
        wr_size    = SIZE_BYTE;
        wr_data    = '0;
        alloc_en   = 1'b0;
        alloc_idx  = '0;
        alloc_size = SIZE_BYTE;
        alloc_tag  = '0;
        cdb_en     = 1'b0;
        cdb_tag    = '0;
        flush      = 1'b0;
        rd_en      = 1'b0;
        rd_idx     = '0;
        rd_size    = SIZE_BYTE;
    endtask

    // Drives one cycle of random traffic and steps the model to match
    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] r2;
        r          = next_random();
        r2         = next_random();
        wr_en      = r[0];
        alloc_en   = (r[3:1] < 3'd3);
        cdb_en     = (r[6:4] < 3'd3);
        flush      = (r[12:7] == 6'd0);
        rd_en      = (r[15:13] != 3'd0);
        wr_idx     = r[18:16];
        alloc_idx  = r[21:19];
        rd_idx     = r[24:22];
        wr_size    = size_t'(2'(r2[7:0] % 3));
        alloc_size = size_t'(2'(r2[15:8] % 3));
        rd_size    = size_t'(2'(r2[23:16] % 3));
        alloc_tag  = r2[30:24];
        // Broadcast a recently allocated tag so that matches happen
        cdb_tag    = recent_tags[r[27:25]];
        wr_data    = next_random();
        if (alloc_en) begin
            recent_tags[pool_ptr] = alloc_tag;
            pool_ptr = (pool_ptr + 1) % 8;
        end
        // Sampled at the next edge and due two edges after that
        if (rd_en) begin
            exp_q.push_back(predict_read(rd_idx, rd_size, edge_cnt + 3));
        end
        model_update(wr_en, wr_idx, wr_size, wr_data, alloc_en, alloc_idx, alloc_size,
                     alloc_tag, cdb_en, cdb_tag, flush);
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            if (edge_cnt > 0) begin
                assert (rd_valid === 1'b0)
                    else report_failure("rd_valid is high while reset is asserted");
            end
        end else if (rd_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("rd_valid is high with no read outstanding");
            end else begin
                head = exp_q.pop_front();
                assert (edge_cnt == head.due)
                    else value_mismatch("read return edge", edge_cnt, head.due);
                assert (rd_data === head.data)
                    else value_mismatch("rd_data", rd_data, head.data);
                assert (rd_busy === head.busy)
                    else value_mismatch("rd_busy", rd_busy, head.busy);
                assert (rd_tag === head.tag)
                    else value_mismatch("rd_tag", rd_tag, head.tag);
                checked++;
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= edge_cnt) begin
            report_failure("rd_valid did not rise two edges after the read was sampled");
        end
    end

    always @(posedge clk) begin
        if (edge_cnt >= TIMEOUT_CYCLES) begin
            report_failure("Timeout, the run went past its cycle limit");
        end
    end

    initial begin
        drive_idle();
        rst_n = 1'b0;
        model_reset();
        for (int i = 0; i < 8; i++) begin
            recent_tags[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            drive_random();
            @(posedge clk);
            #1;
        end
        drive_idle();
        drain = 0;
        while (exp_q.size() != 0 && drain < 8) begin
            @(posedge clk);
            drain++;
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            report_failure("reads were still outstanding at the end of the test");
        end else begin
            $display("%0d reads checked", checked);
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* gpr_regfile.f */
+incdir+tb
verilog/gpr_pkg.sv
verilog/size_decode.sv
verilog/gpr_slot.sv
verilog/gpr_array.sv
verilog/read_format.sv
verilog/gpr_regfile.sv
tb/gpr_regfile_tb.sv
